// File: design/core_pkg.sv
////////////////////////////////////////
// rv32i subset core definitions
////////////////////////////////////////
`default_nettype none

package core_pkg;

  parameter int XLEN = 32;  // data and address width

  // major opcodes, only the ones the core executes
  typedef enum logic [6:0] {
    OP     = 7'b0110011,  // reg-reg alu
    OP_IMM = 7'b0010011,  // reg-imm alu
    LUI    = 7'b0110111,
    STORE  = 7'b0100011   // sw only
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_AND   = 4'd2,
    ALU_OR    = 4'd3,
    ALU_XOR   = 4'd4,
    ALU_SLL   = 4'd5,
    ALU_SRL   = 4'd6,
    ALU_SRA   = 4'd7,
    ALU_SLT   = 4'd8,
    ALU_SLTU  = 4'd9,
    ALU_PASSB = 4'd10   // lui result
  } alu_op_e;

  ////////////////////////////////////////
  // instruction word views
  ////////////////////////////////////////
  typedef struct packed {
    logic [6:0] funct7;  // also imm[11:5] of the shift immediates
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_hi;  // imm[11:5]
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;  // imm[4:0]
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic [19:0] imm;    // upper 20 bits of the result
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  // one fetched word, read through whichever format fits the opcode
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    u_type_t u;
  } instr_u;

  parameter logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

endpackage

`default_nettype wire

// File: design/alu.sv
////////////////////////////////////////
// integer alu
////////////////////////////////////////
`default_nettype none

module alu (
  input  core_pkg::alu_op_e         op_i,
  input  logic [core_pkg::XLEN-1:0] operand_a_i,
  input  logic [core_pkg::XLEN-1:0] operand_b_i,
  output logic [core_pkg::XLEN-1:0] result_o
);
  import core_pkg::*;

  logic [4:0] shamt;   // rv32 shift amount
  logic       lt_s;
  logic       lt_u;

  assign shamt = operand_b_i[4:0];
  assign lt_s  = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_u  = operand_a_i < operand_b_i;

  always_comb
  begin
    case (op_i)
      ALU_ADD:   result_o = operand_a_i + operand_b_i;
      ALU_SUB:   result_o = operand_a_i - operand_b_i;
      ALU_AND:   result_o = operand_a_i & operand_b_i;
      ALU_OR:    result_o = operand_a_i | operand_b_i;
      ALU_XOR:   result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:   result_o = operand_a_i << shamt;
      ALU_SRL:   result_o = operand_a_i >> shamt;
      ALU_SRA:   result_o = $signed(operand_a_i) >>> shamt;  // sign fill
      ALU_SLT:   result_o = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU:  result_o = {{(XLEN-1){1'b0}}, lt_u};
      ALU_PASSB: result_o = operand_b_i;
      default:   result_o = operand_a_i + operand_b_i;     // unused codes
    endcase
  end

endmodule

`default_nettype wire

// File: design/register_file.sv
////////////////////////////////////////
// integer register file
////////////////////////////////////////
`default_nettype none

module register_file #(
  parameter int N_REGS = 32
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [$clog2(N_REGS)-1:0]   raddr_a_i,
  input  logic [$clog2(N_REGS)-1:0]   raddr_b_i,
  output logic [core_pkg::XLEN-1:0]   rdata_a_o,
  output logic [core_pkg::XLEN-1:0]   rdata_b_o,
  input  logic                        we_i,
  input  logic [$clog2(N_REGS)-1:0]   waddr_i,
  input  logic [core_pkg::XLEN-1:0]   wdata_i
);
  import core_pkg::*;

  logic [XLEN-1:0] regs_q [N_REGS];

  // x0 cleared at reset and never written, so it reads zero
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < N_REGS; i++)
        regs_q[i] <= '0;
    end
    else if (we_i && waddr_i != '0)
      regs_q[waddr_i] <= wdata_i;
  end

  // combinational reads, same-cycle write not visible (decode forwards)
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

`default_nettype wire

// File: design/fetch_unit.sv
////////////////////////////////////////
// instruction fetch
////////////////////////////////////////
`default_nettype none

module fetch_unit (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [core_pkg::XLEN-1:0] boot_addr_i,
  input  logic                      fetch_enable_i,
  // instruction memory port
  output logic                      instr_req_o,
  output logic [core_pkg::XLEN-1:0] instr_addr_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  logic [core_pkg::XLEN-1:0] instr_rdata_i,
  // to decode
  output core_pkg::instr_u          instr_o,
  output logic                      instr_valid_o,
  input  logic                      consume_i,
  output logic                      busy_o
);
  import core_pkg::*;

  logic            boot_q;       // no grant seen since reset
  logic [XLEN-1:0] pc_q;         // next sequential fetch address
  logic            req_q;        // request waiting for grant
  logic            pend_q;       // granted, data not back yet
  instr_u          buf_q;
  logic            buf_valid_q;
  logic            raise;

  // one read at a time, and only into a buffer that is empty or emptying
  assign raise = fetch_enable_i & ~req_q & ~pend_q & (~buf_valid_q | consume_i);

  assign instr_req_o  = req_q;
  assign instr_addr_o = boot_q ? boot_addr_i : pc_q;  // boot address until 1st grant

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      boot_q <= 1'b1;
      pc_q   <= '0;
      req_q  <= 1'b0;
      pend_q <= 1'b0;
    end
    else
    begin
      if (raise)
        req_q <= 1'b1;
      else if (req_q && instr_gnt_i)
      begin
        req_q  <= 1'b0;
        pend_q <= 1'b1;
        boot_q <= 1'b0;
        pc_q   <= instr_addr_o + XLEN'(4);  // address held until here
      end
      if (pend_q && instr_rvalid_i)
        pend_q <= 1'b0;   // grant and rvalid of one read never share a cycle
    end
  end

  // one-entry buffer, registered read data
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      buf_q       <= NOP_INSTR;
      buf_valid_q <= 1'b0;
    end
    else if (pend_q && instr_rvalid_i)
    begin
      buf_q       <= instr_rdata_i;
      buf_valid_q <= 1'b1;
    end
    else if (consume_i)
      buf_valid_q <= 1'b0;
  end

  assign instr_o       = buf_q;
  assign instr_valid_o = buf_valid_q;
  assign busy_o        = req_q | pend_q | buf_valid_q;

endmodule

`default_nettype wire

// File: design/decoder.sv
////////////////////////////////////////
// instruction decode
////////////////////////////////////////
`default_nettype none

module decoder #(
  parameter int N_REGS = 32
) (
  input  core_pkg::instr_u            instr_i,
  input  logic                        instr_valid_i,
  output logic                        consume_o,
  // register file read
  output logic [$clog2(N_REGS)-1:0]   rs1_o,
  output logic [$clog2(N_REGS)-1:0]   rs2_o,
  input  logic [core_pkg::XLEN-1:0]   rdata_a_i,
  input  logic [core_pkg::XLEN-1:0]   rdata_b_i,
  // forwarding from write-back
  input  logic                        fwd_we_i,
  input  logic [$clog2(N_REGS)-1:0]   fwd_waddr_i,
  input  logic [core_pkg::XLEN-1:0]   fwd_wdata_i,
  // to execute
  input  logic                        ex_ready_i,
  output logic                        id_valid_o,
  output core_pkg::alu_op_e           alu_op_o,
  output logic [core_pkg::XLEN-1:0]   operand_a_o,
  output logic [core_pkg::XLEN-1:0]   operand_b_o,
  output logic [$clog2(N_REGS)-1:0]   rd_o,
  output logic                        rd_we_o,
  output logic                        store_o,
  output logic [core_pkg::XLEN-1:0]   store_data_o
);
  import core_pkg::*;

  localparam int AW = $clog2(N_REGS);

  logic            legal;
  logic            use_imm;                    // operand b from the immediate
  logic            uses_rs1, uses_rs2, uses_rd;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] fwd_a, fwd_b;

  // funct3 to alu op, shared by OP and OP_IMM
  function automatic alu_op_e f3_op(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb
  begin
    legal    = 1'b0;
    use_imm  = 1'b0;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    uses_rd  = 1'b0;
    store_o  = 1'b0;
    alu_op_o = ALU_ADD;
    imm      = '0;
    case (instr_i.r.opcode)
      OP:
      begin
        // only add/sub and srl/sra have an alternate funct7
        legal    = (instr_i.r.funct7 == 7'b0000000) ||
                   (instr_i.r.funct7 == 7'b0100000 && instr_i.r.funct3 inside {3'b000, 3'b101});
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        uses_rd  = 1'b1;
        alu_op_o = f3_op(instr_i.r.funct3, instr_i.r.funct7[5]);
      end
      OP_IMM:
      begin
        imm      = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
        use_imm  = 1'b1;
        uses_rs1 = 1'b1;
        uses_rd  = 1'b1;
        legal    = 1'b1;
        if (instr_i.i.funct3 == 3'b001)
          legal = (instr_i.r.funct7 == 7'b0000000);  // slli
        else if (instr_i.i.funct3 == 3'b101)
          legal = (instr_i.r.funct7 == 7'b0000000) || (instr_i.r.funct7 == 7'b0100000);
        // imm bit 10 means sra only for the shift encoding
        alu_op_o = f3_op(instr_i.i.funct3, (instr_i.i.funct3 == 3'b101) & instr_i.r.funct7[5]);
      end
      LUI:
      begin
        imm      = {instr_i.u.imm, 12'b0};
        use_imm  = 1'b1;
        uses_rd  = 1'b1;
        legal    = 1'b1;
        alu_op_o = ALU_PASSB;
      end
      STORE:
      begin
        imm      = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
        use_imm  = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        store_o  = 1'b1;
        legal    = (instr_i.s.funct3 == 3'b010);  // sw only
      end
      default: ;
    endcase
    // register index beyond the configured file
    if ((uses_rs1 && int'(instr_i.r.rs1) >= N_REGS) ||
        (uses_rs2 && int'(instr_i.r.rs2) >= N_REGS) ||
        (uses_rd  && int'(instr_i.r.rd)  >= N_REGS))
      legal = 1'b0;
  end

  assign rs1_o = instr_i.r.rs1[AW-1:0];
  assign rs2_o = instr_i.r.rs2[AW-1:0];
  assign rd_o  = instr_i.r.rd[AW-1:0];

  // write-back target this cycle wins over the stale file value
  assign fwd_a = (fwd_we_i && fwd_waddr_i == rs1_o) ? fwd_wdata_i : rdata_a_i;
  assign fwd_b = (fwd_we_i && fwd_waddr_i == rs2_o) ? fwd_wdata_i : rdata_b_i;

  assign operand_a_o  = fwd_a;
  assign operand_b_o  = use_imm ? imm : fwd_b;
  assign store_data_o = fwd_b;
  assign rd_we_o      = uses_rd & (rd_o != '0);  // x0 never written

  assign consume_o  = instr_valid_i & ex_ready_i;  // illegal words drop here as no-ops
  assign id_valid_o = instr_valid_i & legal;

endmodule

`default_nettype wire

// File: design/execute_stage.sv
////////////////////////////////////////
// execute and write-back
////////////////////////////////////////
`default_nettype none

module execute_stage #(
  parameter int N_REGS = 32
) (
  input  logic                        clk,
  input  logic                        rst_n,
  // from decode
  input  logic                        id_valid_i,
  input  core_pkg::alu_op_e           alu_op_i,
  input  logic [core_pkg::XLEN-1:0]   operand_a_i,
  input  logic [core_pkg::XLEN-1:0]   operand_b_i,
  input  logic [$clog2(N_REGS)-1:0]   rd_i,
  input  logic                        rd_we_i,
  input  logic                        store_i,
  input  logic [core_pkg::XLEN-1:0]   store_data_i,
  output logic                        ready_o,
  // write-back, also the forwarding source
  output logic                        we_o,
  output logic [$clog2(N_REGS)-1:0]   waddr_o,
  output logic [core_pkg::XLEN-1:0]   wdata_o,
  // store-only data port
  output logic                        data_req_o,
  output logic [core_pkg::XLEN-1:0]   data_addr_o,
  output logic [core_pkg::XLEN-1:0]   data_wdata_o,
  input  logic                        data_gnt_i,
  output logic                        busy_o
);
  import core_pkg::*;

  logic                      valid_q;
  alu_op_e                   alu_op_q;
  logic [XLEN-1:0]           op_a_q, op_b_q;
  logic [$clog2(N_REGS)-1:0] rd_q;
  logic                      rd_we_q;
  logic                      store_q;
  logic [XLEN-1:0]           sdata_q;   // rs2 value of a store
  logic [XLEN-1:0]           result;

  alu alu_inst (
    .op_i        ( alu_op_q ),
    .operand_a_i ( op_a_q   ),
    .operand_b_i ( op_b_q   ),
    .result_o    ( result   )
  );

  ////////////////////////////////////////
  // pipeline register
  ////////////////////////////////////////
  // a store holds everything until its grant
  assign ready_o = ~data_req_o | data_gnt_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      valid_q <= 1'b0;
    else if (ready_o)
      valid_q <= id_valid_i;  // empties when decode has nothing
  end

  always_ff @(posedge clk)
  begin
    if (ready_o && id_valid_i)
    begin
      alu_op_q <= alu_op_i;
      op_a_q   <= operand_a_i;
      op_b_q   <= operand_b_i;
      rd_q     <= rd_i;
      rd_we_q  <= rd_we_i;
      store_q  <= store_i;
      sdata_q  <= store_data_i;
    end
  end

  // written on the edge after load
  assign we_o    = valid_q & rd_we_q;
  assign waddr_o = rd_q;
  assign wdata_o = result;

  // request straight from the register, word aligned
  assign data_req_o   = valid_q & store_q;
  assign data_addr_o  = {result[XLEN-1:2], 2'b00};
  assign data_wdata_o = sdata_q;

  assign busy_o = valid_q;

endmodule

`default_nettype wire

// File: design/rv_core.sv
////////////////////////////////////////
// three-stage rv32i subset core
////////////////////////////////////////
`default_nettype none

module rv_core #(
  parameter int N_REGS = 32   // 16 or 32
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [core_pkg::XLEN-1:0] boot_addr_i,
  input  logic                      fetch_enable_i,
  // instruction memory
  output logic                      instr_req_o,
  output logic [core_pkg::XLEN-1:0] instr_addr_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  logic [core_pkg::XLEN-1:0] instr_rdata_i,
  // data memory, word stores only
  output logic                      data_req_o,
  output logic [core_pkg::XLEN-1:0] data_addr_o,
  output logic [core_pkg::XLEN-1:0] data_wdata_o,
  input  logic                      data_gnt_i,
  output logic                      core_busy_o
);
  import core_pkg::*;

  localparam int AW = $clog2(N_REGS);

  instr_u          instr_if;
  logic            instr_valid_if, consume_id;
  logic [AW-1:0]   rs1_id, rs2_id;
  logic [XLEN-1:0] rdata_a, rdata_b;
  logic            wb_we;
  logic [AW-1:0]   wb_waddr;
  logic [XLEN-1:0] wb_wdata;
  logic            ex_ready, id_valid;
  alu_op_e         alu_op_id;
  logic [XLEN-1:0] operand_a_id, operand_b_id, store_data_id;
  logic [AW-1:0]   rd_id;
  logic            rd_we_id, store_id;
  logic            if_busy, ex_busy;

  ////////////////////////////////////////
  // fetch
  ////////////////////////////////////////
  fetch_unit fetch_unit_inst (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .instr_o        ( instr_if       ),
    .instr_valid_o  ( instr_valid_if ),
    .consume_i      ( consume_id     ),
    .busy_o         ( if_busy        )
  );

  ////////////////////////////////////////
  // decode and register read
  ////////////////////////////////////////
  decoder #(.N_REGS(N_REGS)) decoder_inst (
    .instr_i       ( instr_if       ),
    .instr_valid_i ( instr_valid_if ),
    .consume_o     ( consume_id     ),
    .rs1_o         ( rs1_id         ),
    .rs2_o         ( rs2_id         ),
    .rdata_a_i     ( rdata_a        ),
    .rdata_b_i     ( rdata_b        ),
    .fwd_we_i      ( wb_we          ),
    .fwd_waddr_i   ( wb_waddr       ),
    .fwd_wdata_i   ( wb_wdata       ),
    .ex_ready_i    ( ex_ready       ),
    .id_valid_o    ( id_valid       ),
    .alu_op_o      ( alu_op_id      ),
    .operand_a_o   ( operand_a_id   ),
    .operand_b_o   ( operand_b_id   ),
    .rd_o          ( rd_id          ),
    .rd_we_o       ( rd_we_id       ),
    .store_o       ( store_id       ),
    .store_data_o  ( store_data_id  )
  );

  register_file #(.N_REGS(N_REGS)) register_file_inst (
    .clk       ( clk      ),
    .rst_n     ( rst_n    ),
    .raddr_a_i ( rs1_id   ),
    .raddr_b_i ( rs2_id   ),
    .rdata_a_o ( rdata_a  ),
    .rdata_b_o ( rdata_b  ),
    .we_i      ( wb_we    ),
    .waddr_i   ( wb_waddr ),
    .wdata_i   ( wb_wdata )
  );

  ////////////////////////////////////////
  // execute, write-back, stores
  ////////////////////////////////////////
  execute_stage #(.N_REGS(N_REGS)) execute_stage_inst (
    .clk          ( clk           ),
    .rst_n        ( rst_n         ),
    .id_valid_i   ( id_valid      ),
    .alu_op_i     ( alu_op_id     ),
    .operand_a_i  ( operand_a_id  ),
    .operand_b_i  ( operand_b_id  ),
    .rd_i         ( rd_id         ),
    .rd_we_i      ( rd_we_id      ),
    .store_i      ( store_id      ),
    .store_data_i ( store_data_id ),
    .ready_o      ( ex_ready      ),
    .we_o         ( wb_we         ),
    .waddr_o      ( wb_waddr      ),
    .wdata_o      ( wb_wdata      ),
    .data_req_o   ( data_req_o    ),
    .data_addr_o  ( data_addr_o   ),
    .data_wdata_o ( data_wdata_o  ),
    .data_gnt_i   ( data_gnt_i    ),
    .busy_o       ( ex_busy       )
  );

  assign core_busy_o = if_busy | ex_busy;  // read in flight, word buffered or ex valid

endmodule

`default_nettype wire

// File: dv/tb_checker.sv
////////////////////////////////////////
// reference model and checks
////////////////////////////////////////
`default_nettype none

module tb_checker #(
  parameter int N_REGS = 32
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] boot_addr_i,
  input  logic        fetch_enable_i,
  input  logic        instr_req_i,
  input  logic [31:0] instr_addr_i,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i,
  input  logic        data_req_i,
  input  logic [31:0] data_addr_i,
  input  logic [31:0] data_wdata_i,
  input  logic        data_gnt_i,
  input  logic        core_busy_i,
  output int          fetch_err_o,
  output int          store_err_o,
  output int          pause_err_o,
  output int          fetch_cnt_o,
  output int          store_cnt_o,
  output int          dep_cnt_o,
  output int          nop_cnt_o,
  output int          pending_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import core_pkg::*;

  logic [31:0] regs [32];      // architectural state, x0 stays zero
  logic [63:0] exp_q [$];      // {addr, data} of stores in program order
  logic [31:0] exp_addr;
  logic        first = 1'b1;
  logic        req_prev = 1'b0, en_prev = 1'b0;
  logic [4:0]  last_rd = '0;   // writer of the previous instruction
  int          reads_open = 0; // granted reads without data yet

  initial
  begin
    for (int k = 0; k < 32; k++)
      regs[k] = '0;
    {fetch_err_o, store_err_o, fetch_cnt_o, store_cnt_o} = '0;
    {dep_cnt_o, nop_cnt_o, pending_o, pause_err_o} = '0;
  end

  // rv32i integer result from funct3
  function automatic logic [31:0] calc(input logic [2:0] f3, input logic alt,
                                       input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic step_model(input logic [31:0] word);
    instr_u      u;
    logic [31:0] a, b, res, simm;
    logic        legal, wr, in_range;
    u        = word;
    a        = regs[u.r.rs1];
    b        = regs[u.r.rs2];
    legal    = 1'b0;
    wr       = 1'b0;
    res      = '0;
    in_range = int'(u.r.rd) < N_REGS && int'(u.r.rs1) < N_REGS;
    case (u.r.opcode)
      7'b0110011:
      begin
        legal = (u.r.funct7 == 7'h00 || (u.r.funct7 == 7'h20 && u.r.funct3 inside {0, 5}))
                && in_range && int'(u.r.rs2) < N_REGS;
        wr    = 1'b1;
        res   = calc(u.r.funct3, u.r.funct7[5], a, b);
      end
      7'b0010011:
      begin
        simm  = {{20{u.i.imm[11]}}, u.i.imm};
        legal = in_range;
        if (u.i.funct3 == 3'd1)
          legal = legal && u.r.funct7 == 7'h00;
        else if (u.i.funct3 == 3'd5)
          legal = legal && (u.r.funct7 == 7'h00 || u.r.funct7 == 7'h20);
        wr  = 1'b1;
        res = calc(u.i.funct3, u.i.funct3 == 3'd5 && u.r.funct7[5], a, simm);
      end
      7'b0110111:
      begin
        legal = int'(u.u.rd) < N_REGS;
        wr    = 1'b1;
        res   = {u.u.imm, 12'b0};
      end
      7'b0100011:
      begin
        simm  = {{20{u.s.imm_hi[6]}}, u.s.imm_hi, u.s.imm_lo};
        legal = u.s.funct3 == 3'd2 && int'(u.s.rs1) < N_REGS && int'(u.s.rs2) < N_REGS;
        if (legal)
          exp_q.push_back({(a + simm) & 32'hFFFF_FFFC, b});
      end
      default: ;
    endcase
    if (legal && wr && u.r.rd != 0)
    begin
      if (u.r.opcode != 7'b0110111 && u.r.rs1 == last_rd && last_rd != 0)
        dep_cnt_o++;
      regs[u.r.rd] = res;
      last_rd      = u.r.rd;
    end
    else
    begin
      if (!legal || wr)
        nop_cnt_o++;   // illegal word or x0 target
      last_rd = '0;
    end
  endtask

  ////////////////////////////////////////
  // sampled mid-cycle, values settled
  ////////////////////////////////////////
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (instr_req_i && !req_prev && !en_prev)
      begin
        $display("** Error at %0t: fetch request raised while disabled", $time);
        pause_err_o++;
      end
      if (instr_req_i && instr_gnt_i)
      begin
        if (first)
          exp_addr = boot_addr_i;
        if (instr_addr_i != exp_addr)
        begin
          $display("** Error at %0t: fetch addr %h, expected %h", $time, instr_addr_i, exp_addr);
          fetch_err_o++;
        end
        first    = 1'b0;
        exp_addr = instr_addr_i + 32'd4;
        fetch_cnt_o++;
        reads_open++;
      end
      if (instr_rvalid_i)
      begin
        step_model(instr_rdata_i);   // program order
        reads_open--;
      end
      if (data_req_i && data_gnt_i)
      begin
        if (exp_q.size() == 0)
        begin
          $display("** Error at %0t: unexpected store to %h", $time, data_addr_i);
          store_err_o++;
        end
        else if ({data_addr_i, data_wdata_i} != exp_q[0])
        begin
          $display("** Error at %0t: store %h <- %h, expected %h <- %h", $time, data_addr_i,
                   data_wdata_i, exp_q[0][63:32], exp_q[0][31:0]);
          store_err_o++;
        end
        if (exp_q.size() != 0)
          void'(exp_q.pop_front());
        store_cnt_o++;
      end
      // idle core with a request, a read or a store still in flight
      if (!core_busy_i && (instr_req_i || data_req_i || reads_open != 0 || exp_q.size() != 0))
      begin
        $display("** Error at %0t: core_busy_o low with work in flight", $time);
        pause_err_o++;
      end
      pending_o = exp_q.size();
    end
    req_prev = instr_req_i;
    en_prev  = fetch_enable_i;
  end

endmodule

`default_nettype wire

// File: dv/tb_top.sv
////////////////////////////////////////
// rv_core testbench top
////////////////////////////////////////
`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_REGS    = 32;
  localparam int N_WORDS   = 200;
  localparam int MAX_CYCLE = N_WORDS * 12 + 100;  // hang limit

  logic        clk = 1'b0;
  logic        rst_n;
  logic [31:0] boot_addr_i;
  logic        fetch_enable_i;
  logic        instr_req_o, instr_gnt_i, instr_rvalid_i;
  logic [31:0] instr_addr_o, instr_rdata_i;
  logic        data_req_o, data_gnt_i, core_busy_o;
  logic [31:0] data_addr_o, data_wdata_o;

  logic [31:0] lfsr_state = 32'd71;
  logic [31:0] prog [N_WORDS];
  logic [1:0]  igap, dgap;           // grant wait cycles left
  logic        rpend;                // read data delayed one more cycle
  logic [31:0] rword;
  int          n_granted = 0;
  int          cycles = 0;
  int          fetch_err, store_err, fetch_cnt, store_cnt, dep_cnt, nop_cnt, pending;
  int          pause_err;
  int          total_err;

  always #2 clk = ~clk;  // 4 ns period

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rbits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - boot_addr_i) >> 2;
    return (idx < N_WORDS) ? prog[idx] : core_pkg::NOP_INSTR;  // nops past the end
  endfunction

  ////////////////////////////////////////
  // random program, x0..x7 only
  ////////////////////////////////////////
  task automatic gen_program();
    logic [4:0]  rd, rs1, rs2, prev_rd;
    logic [3:0]  kind;
    logic [2:0]  f3;
    logic [11:0] imm;
    prev_rd = 5'd1;
    for (int i = 0; i < N_WORDS; i++)
    begin
      rd   = 5'(rbits(3));
      rs1  = 5'(rbits(3));
      rs2  = 5'(rbits(3));
      kind = 4'(rbits(4));
      f3   = 3'(rbits(3));
      if (i % 3 == 2)
      begin
        rs1  = prev_rd;            // back-to-back dependency
        kind = 4'(rbits(3));       // alu only
      end
      if (kind <= 4)
        prog[i] = {((f3 == 0 || f3 == 5) && rbits(1)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd,
                   7'b0110011};
      else if (kind <= 8)
      begin
        imm = 12'(rbits(12));
        if (f3 == 3'b001)
          imm[11:5] = 7'h00;
        else if (f3 == 3'b101)
          imm[11:5] = rbits(1) ? 7'h20 : 7'h00;
        prog[i] = {imm, rs1, f3, rd, 7'b0010011};
      end
      else if (kind == 9)
        prog[i] = {20'(rbits(20)), rd, 7'b0110111};
      else if (kind == 13)
        prog[i] = rbits(1) ? {25'(rbits(25)), 7'b0000011} : {7'h01, rs2, rs1, f3, rd, 7'b0110011};
      else if (kind == 14)
        prog[i] = {12'(rbits(12)), rs1, 3'b000, 5'd0, 7'b0010011};  // addi to x0
      else
      begin
        imm     = 12'(rbits(12));
        prog[i] = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
      end
      if (kind <= 9)
        prev_rd = rd;
    end
  endtask

  ////////////////////////////////////////
  // memory ports with random waits
  ////////////////////////////////////////
  always @(posedge clk)
  begin
    instr_rvalid_i <= 1'b0;
    if (rpend)
    begin
      instr_rvalid_i <= 1'b1;
      instr_rdata_i  <= rword;
      rpend          <= 1'b0;
    end
    if (instr_req_o && instr_gnt_i)
    begin
      instr_gnt_i <= 1'b0;
      igap        <= 2'(rbits(2));
      n_granted   <= n_granted + 1;
      rword       <= mem_word(instr_addr_o);
      if (rbits(1))
        rpend <= 1'b1;               // data two cycles after grant
      else
      begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= mem_word(instr_addr_o);
      end
    end
    else if (instr_req_o)
    begin
      if (igap == 0)
        instr_gnt_i <= 1'b1;
      else
        igap <= igap - 2'd1;
    end
    if (data_req_o && data_gnt_i)
    begin
      data_gnt_i <= 1'b0;
      dgap       <= 2'(rbits(2));
    end
    else if (data_req_o)
    begin
      if (dgap == 0)
        data_gnt_i <= 1'b1;
      else
        dgap <= dgap - 2'd1;
    end
  end

  // hang guard
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLE)
    begin
      $display("run hung: no finish after %0d cycles", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // busy sampled mid-cycle
  task automatic wait_idle();
    repeat (2) @(posedge clk);
    @(negedge clk);
    while (core_busy_o)
      @(negedge clk);
  endtask

  rv_core #(.N_REGS(N_REGS)) rv_core_inst (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .data_req_o     ( data_req_o     ),
    .data_addr_o    ( data_addr_o    ),
    .data_wdata_o   ( data_wdata_o   ),
    .data_gnt_i     ( data_gnt_i     ),
    .core_busy_o    ( core_busy_o    )
  );

  tb_checker #(.N_REGS(N_REGS)) tb_checker_inst (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_req_i    ( instr_req_o    ),
    .instr_addr_i   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .data_req_i     ( data_req_o     ),
    .data_addr_i    ( data_addr_o    ),
    .data_wdata_i   ( data_wdata_o   ),
    .data_gnt_i     ( data_gnt_i     ),
    .core_busy_i    ( core_busy_o    ),
    .fetch_err_o    ( fetch_err      ),
    .store_err_o    ( store_err      ),
    .pause_err_o    ( pause_err      ),
    .fetch_cnt_o    ( fetch_cnt      ),
    .store_cnt_o    ( store_cnt      ),
    .dep_cnt_o      ( dep_cnt        ),
    .nop_cnt_o      ( nop_cnt        ),
    .pending_o      ( pending        )
  );

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial
  begin
    rst_n          <= 1'b0;
    fetch_enable_i <= 1'b0;
    instr_gnt_i    <= 1'b0;
    instr_rvalid_i <= 1'b0;
    instr_rdata_i  <= '0;
    data_gnt_i     <= 1'b0;
    rpend          <= 1'b0;
    rword          <= '0;
    boot_addr_i    <= rbits(32) & 32'hFFFF_FFFC;  // word aligned
    igap           <= 2'(rbits(2));
    dgap           <= 2'(rbits(2));
    gen_program();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    fetch_enable_i <= 1'b1;
    while (n_granted < N_WORDS / 2)
      @(posedge clk);
    // pause mid-run, pipeline must drain and stay quiet
    fetch_enable_i <= 1'b0;
    wait_idle();
    repeat (8) @(posedge clk);   // quiet window under the checker
    fetch_enable_i <= 1'b1;
    $display("fetch enable pause: %0d errors", pause_err);
    while (n_granted < N_WORDS)
      @(posedge clk);
    fetch_enable_i <= 1'b0;
    wait_idle();
    repeat (4) @(posedge clk);
    if (pending != 0)
      $display("%0d expected stores never reached the data port", pending);
    $display("fetch order: %0d fetches, %0d errors", fetch_cnt, fetch_err);
    $display("store stream: %0d stores, %0d errors, %0d left", store_cnt, store_err, pending);
    $display("forwarding: %0d dependent pairs covered by the store checks", dep_cnt);
    $display("x0 writes and illegal words: %0d no-ops covered", nop_cnt);
    total_err = fetch_err + store_err + pause_err + pending;
    $display("counts: %0d fetches, %0d stores, %0d errors", fetch_cnt, store_cnt, total_err);
    if (total_err == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
design/core_pkg.sv
design/alu.sv
design/register_file.sv
design/fetch_unit.sv
design/decoder.sv
design/execute_stage.sv
design/rv_core.sv
dv/tb_checker.sv
dv/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_top -f all.f -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -q "TESTBENCH PASSED"; then
  exit 0
else
  exit 1
fi
